//--- verilog/fetch_pkg.sv
// fetch_pkg: sizes, memory command and tag types, fetch address union, port structs
`default_nettype none

package fetch_pkg;

	//////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////

	// address and instruction width
	parameter int xlen = 32;
	// one cache line equals one memory beat
	parameter int line_bytes = 8;
	parameter int line_bits = line_bytes * 8;
	parameter int line_offset_bits = $clog2(line_bytes);
	// line count handed to the top level
	parameter int default_cache_lines = 32;
	parameter int default_index_bits = $clog2(default_cache_lines);
	parameter int default_tag_bits = xlen - default_index_bits - line_offset_bits;
	// first fetch address
	parameter logic [xlen-1:0] reset_pc = '0;

	//////////////////////////////////////////////////
	// memory bus types
	//////////////////////////////////////////////////

	// store encoding kept, never issued by fetch
	typedef enum logic [1:0] {
		cmd_none  = 2'h0,
		cmd_load  = 2'h1,
		cmd_store = 2'h2
	} mem_command_t;

	// zero means no transaction
	typedef logic [3:0] mem_tag_t;

	// field view of a fetch address
	typedef struct packed {
		logic [default_tag_bits-1:0]   tag;
		logic [default_index_bits-1:0] index;
		logic                          word_sel;
		logic [1:0]                    byte_off;
	} fetch_fields_t;

	// same word, raw or decoded
	typedef union packed {
		logic [xlen-1:0] raw;
		fetch_fields_t   fields;
	} fetch_addr_t;

	// request toward memory
	typedef struct packed {
		mem_command_t    command;
		logic [xlen-1:0] addr;
	} mem_req_t;

	// accept tag, reply tag and returned line
	typedef struct packed {
		mem_tag_t             response;
		mem_tag_t             tag;
		logic [line_bits-1:0] data;
	} mem_rsp_t;

	// pc change from the back end
	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] target;
	} redirect_t;

	// one instruction toward decode
	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] inst;
	} fetch_packet_t;

endpackage

`default_nettype wire

//--- verilog/icache_mem.sv
// icache_mem: direct-mapped line storage with tag and valid arrays
`timescale 1ns/100ps
`default_nettype none

module icache_mem #(
	parameter int cache_lines = fetch_pkg::default_cache_lines,
	localparam int index_bits = $clog2(cache_lines),
	localparam int tag_bits = fetch_pkg::xlen - index_bits - fetch_pkg::line_offset_bits
) (
	input  logic                           clock,
	input  logic                           rst_n,
	// read port, looked up every cycle
	input  logic [index_bits-1:0]          rd_index,
	input  logic [tag_bits-1:0]            rd_tag,
	// fill port from the controller
	input  logic                           wr_en,
	input  logic [index_bits-1:0]          wr_index,
	input  logic [tag_bits-1:0]            wr_tag,
	input  logic [fetch_pkg::line_bits-1:0] wr_data,
	// lookup result
	output logic [fetch_pkg::line_bits-1:0] rd_data,
	output logic                           rd_valid,
	output logic                           rd_tag_match
);
	import fetch_pkg::*;

	//////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////

	// line payload
	logic [line_bits-1:0] data_array [cache_lines];
	// stored upper address bits
	logic [tag_bits-1:0]  tag_array [cache_lines];
	// one bit per line
	logic [cache_lines-1:0] valid_bits;

	// valid bits cleared on reset so the first fetch misses
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			valid_bits <= '0;
		end else if (wr_en) begin
			valid_bits[wr_index] <= 1'b1;
		end
	end

	// payload and tag written at the edge
	always_ff @(posedge clock) begin
		if (wr_en) begin
			data_array[wr_index] <= wr_data;
			tag_array[wr_index]  <= wr_tag;
		end
	end

	//////////////////////////////////////////////////
	// combinational read
	//////////////////////////////////////////////////

	// written value visible only after the edge
	always_comb begin
		rd_data      = data_array[rd_index];
		rd_valid     = valid_bits[rd_index];
		rd_tag_match = (tag_array[rd_index] == rd_tag);
	end

endmodule

`default_nettype wire

//--- verilog/icache_ctrl.sv
// icache_ctrl: hit check, miss request, response tag capture and fill control
`timescale 1ns/100ps
`default_nettype none

module icache_ctrl #(
	parameter int cache_lines = fetch_pkg::default_cache_lines,
	localparam int index_bits = $clog2(cache_lines),
	localparam int tag_bits = fetch_pkg::xlen - index_bits - fetch_pkg::line_offset_bits
) (
	input  logic                  clock,
	input  logic                  rst_n,
	// current fetch address
	input  fetch_pkg::fetch_addr_t pc,
	// memory side
	input  fetch_pkg::mem_rsp_t   mem_rsp,
	// lookup result from the line store
	input  logic                  rd_valid,
	input  logic                  rd_tag_match,
	output logic                  hit,
	// lookup address into the line store
	output logic [index_bits-1:0] rd_index,
	output logic [tag_bits-1:0]   rd_tag,
	// fill control
	output logic                  wr_en,
	output logic [index_bits-1:0] wr_index,
	output logic [tag_bits-1:0]   wr_tag,
	output fetch_pkg::mem_req_t   mem_req
);
	import fetch_pkg::*;

	// block number of the fetch address, offset stripped
	localparam int block_bits = xlen - line_offset_bits;

	logic [block_bits-1:0] block_addr;

	// tag of the outstanding load, zero when idle
	mem_tag_t pending_tag;
	// where the outstanding line lands
	logic [index_bits-1:0] miss_index;
	logic [tag_bits-1:0]   miss_tag;

	logic tag_busy;
	logic issue;
	logic accept;
	logic reply;

	//////////////////////////////////////////////////
	// lookup
	//////////////////////////////////////////////////

	// tag and index fields joined, then split to this cache's size
	assign block_addr = {pc.fields.tag, pc.fields.index};
	assign rd_index   = block_addr[index_bits-1:0];
	assign rd_tag     = block_addr[block_bits-1:index_bits];

	// line present and same upper address
	assign hit = rd_valid & rd_tag_match;

	//////////////////////////////////////////////////
	// miss handling
	//////////////////////////////////////////////////

	assign tag_busy = (pending_tag != '0);

	// only one miss in flight
	// nothing requested while reset is held
	assign issue = rst_n & ~hit & ~tag_busy;

	// nonzero response in the request cycle means taken
	assign accept = issue & (mem_rsp.response != '0);

	// reply carries the captured tag
	assign reply = tag_busy & (mem_rsp.tag == pending_tag);

	// load for the line-aligned address, repeated until taken
	always_comb begin
		mem_req.command = cmd_none;
		mem_req.addr    = {block_addr, {line_offset_bits{1'b0}}};
		if (issue) begin
			mem_req.command = cmd_load;
		end
	end

	// tag held from accept edge to reply edge
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pending_tag <= '0;
		end else if (accept) begin
			pending_tag <= mem_rsp.response;
		end else if (reply) begin
			pending_tag <= '0;
		end
	end

	// fill address recorded with the accept
	// pc may move on before the reply
	always_ff @(posedge clock) begin
		if (accept) begin
			miss_index <= rd_index;
			miss_tag   <= rd_tag;
		end
	end

	//////////////////////////////////////////////////
	// fill
	//////////////////////////////////////////////////

	// one cycle wide
	// pending tag clears at the same edge
	assign wr_en    = reply;
	assign wr_index = miss_index;
	assign wr_tag   = miss_tag;

endmodule

`default_nettype wire

//--- verilog/fetch_pc.sv
// fetch_pc: program counter with stall and redirect, word select, fetch packet
`timescale 1ns/100ps
`default_nettype none

module fetch_pc (
	input  logic                           clock,
	input  logic                           rst_n,
	// hold request from the back end
	input  logic                           stall,
	// new target, single cycle pulse
	input  fetch_pkg::redirect_t           redirect,
	// cache lookup for the current pc
	input  logic                           hit,
	input  logic [fetch_pkg::line_bits-1:0] line,
	output fetch_pkg::fetch_addr_t         pc,
	output fetch_pkg::fetch_packet_t       fetch_packet
);
	import fetch_pkg::*;

	// bytes per instruction
	localparam logic [xlen-1:0] inst_bytes = 32'd4;

	fetch_addr_t pc_next;
	logic        deliver;
	logic [xlen-1:0] inst;

	//////////////////////////////////////////////////
	// next pc
	//////////////////////////////////////////////////

	// a packet leaves only on a hit with nothing blocking it
	assign deliver = hit & ~stall & ~redirect.valid;

	// redirect first, then advance, otherwise hold
	always_comb begin
		pc_next = pc;
		if (redirect.valid) begin
			pc_next.raw = redirect.target;
		end else if (deliver) begin
			pc_next.raw = pc.raw + inst_bytes;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pc.raw <= reset_pc;
		end else begin
			pc <= pc_next;
		end
	end

	//////////////////////////////////////////////////
	// instruction select
	//////////////////////////////////////////////////

	// low word sits at the lower address
	always_comb begin
		if (pc.fields.word_sel) begin
			inst = line[2*xlen-1:xlen];
		end else begin
			inst = line[xlen-1:0];
		end
	end

	// packet to decode
	always_comb begin
		fetch_packet.valid = deliver;
		fetch_packet.pc    = pc.raw;
		fetch_packet.inst  = inst;
	end

endmodule

`default_nettype wire

//--- verilog/fetch_top.sv
// fetch_top: instruction front end with pc, cache controller and line store
`timescale 1ns/100ps
`default_nettype none

module fetch_top #(
	parameter int cache_lines = fetch_pkg::default_cache_lines
) (
	input  logic                     clock,
	input  logic                     rst_n,
	// back end controls
	input  logic                     stall,
	input  fetch_pkg::redirect_t     redirect,
	// tagged memory interface
	input  fetch_pkg::mem_rsp_t      mem_rsp,
	output fetch_pkg::mem_req_t      mem_req,
	// toward decode
	output fetch_pkg::fetch_packet_t fetch_packet
);
	import fetch_pkg::*;

	localparam int index_bits = $clog2(cache_lines);
	localparam int tag_bits = xlen - index_bits - line_offset_bits;

	//////////////////////////////////////////////////
	// internal wires
	//////////////////////////////////////////////////

	// pc to controller, line back to pc
	fetch_addr_t          pc;
	logic                 hit;
	logic [line_bits-1:0] line;

	// controller to line store
	logic [index_bits-1:0] rd_index;
	logic [tag_bits-1:0]   rd_tag;
	logic                  rd_valid;
	logic                  rd_tag_match;
	logic                  wr_en;
	logic [index_bits-1:0] wr_index;
	logic [tag_bits-1:0]   wr_tag;

	//////////////////////////////////////////////////
	// instances
	//////////////////////////////////////////////////

	fetch_pc fetch_pc_inst (
		.clock        (clock),
		.rst_n        (rst_n),
		.stall        (stall),
		.redirect     (redirect),
		.hit          (hit),
		.line         (line),
		.pc           (pc),
		.fetch_packet (fetch_packet)
	);

	icache_ctrl #(
		.cache_lines (cache_lines)
	) icache_ctrl_inst (
		.clock        (clock),
		.rst_n        (rst_n),
		.pc           (pc),
		.mem_rsp      (mem_rsp),
		.rd_valid     (rd_valid),
		.rd_tag_match (rd_tag_match),
		.hit          (hit),
		.rd_index     (rd_index),
		.rd_tag       (rd_tag),
		.wr_en        (wr_en),
		.wr_index     (wr_index),
		.wr_tag       (wr_tag),
		.mem_req      (mem_req)
	);

	// fill data taken straight from the memory reply
	icache_mem #(
		.cache_lines (cache_lines)
	) icache_mem_inst (
		.clock        (clock),
		.rst_n        (rst_n),
		.rd_index     (rd_index),
		.rd_tag       (rd_tag),
		.wr_en        (wr_en),
		.wr_index     (wr_index),
		.wr_tag       (wr_tag),
		.wr_data      (mem_rsp.data),
		.rd_data      (line),
		.rd_valid     (rd_valid),
		.rd_tag_match (rd_tag_match)
	);

endmodule

`default_nettype wire

//--- sim/clock_gen.sv
// clock_gen: testbench clock and active-low reset
`timescale 1ns/100ps
`default_nettype none

module clock_gen #(
	parameter int period = 100,
	parameter int reset_cycles = 10
) (
	output logic clock,
	output logic rst_n
);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	// released on a rising edge, sampled by the testbench at falling edges
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- sim/mem_model.sv
// mem_model: tagged memory with random accept, random reply delay and a seeded image
`timescale 1ns/100ps
`default_nettype none

module mem_model (
	input  logic                clock,
	input  logic                rst_n,
	input  fetch_pkg::mem_req_t mem_req,
	output fetch_pkg::mem_rsp_t mem_rsp
);
	import fetch_pkg::*;

	// 64 KB, one entry per line
	localparam int image_lines = 65536 / line_bytes;

	logic [line_bits-1:0] image [image_lines];

	logic                 roll;
	logic                 busy;
	logic [2:0]           count;
	mem_tag_t             next_tag;
	mem_tag_t             held_tag;
	logic [xlen-1:0]      held_addr;
	mem_tag_t             reply_tag;
	logic [line_bits-1:0] reply_data;

	// word from the image, upper half at the higher address
	function automatic logic [xlen-1:0] read_word(input logic [xlen-1:0] addr);
		logic [line_bits-1:0] entry;
		entry = image[addr[15:3]];
		return addr[2] ? entry[2*xlen-1:xlen] : entry[xlen-1:0];
	endfunction

	// seeded once for the whole run
	initial begin
		void'($urandom(70));
		for (int i = 0; i < image_lines; i++) begin
			image[i] = {$urandom() ^ 32'(i), $urandom() ^ 32'(i << 3)};
		end
	end

	// accept only when idle and the roll says yes
	always_comb begin
		mem_rsp.response = '0;
		if (rst_n && !busy && roll && mem_req.command == cmd_load) begin
			mem_rsp.response = next_tag;
		end
		mem_rsp.tag  = reply_tag;
		mem_rsp.data = reply_data;
	end

	always @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			roll       <= 1'b0;
			busy       <= 1'b0;
			count      <= '0;
			next_tag   <= 4'd1;
			held_tag   <= '0;
			held_addr  <= '0;
			reply_tag  <= '0;
			reply_data <= '0;
		end else begin
			roll      <= 1'($urandom_range(0, 1));
			reply_tag <= '0;
			// reply lasts one cycle
			if (busy) begin
				if (count == 0) begin
					reply_tag  <= held_tag;
					reply_data <= image[held_addr[15:3]];
					busy       <= 1'b0;
				end else begin
					count <= count - 1'b1;
				end
			end
			// delay of 2 to 8 cycles from the accept
			if (mem_rsp.response != '0) begin
				busy      <= 1'b1;
				held_tag  <= mem_rsp.response;
				held_addr <= mem_req.addr;
				count     <= 3'($urandom_range(1, 7));
				next_tag  <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- sim/fetch_tb.sv
// fetch_tb: stimulus, reference model, compare tasks, watchdog and report for fetch_top
`timescale 1ns/100ps
`default_nettype none

module fetch_tb;
	import fetch_pkg::*;

	// summed length of reset, random run, loop-back and reuse in cycles
	localparam int total_cycles = 10 + 600 + 400 + 200;

	logic          clock;
	logic          rst_n;
	logic          stall;
	redirect_t     redirect;
	mem_rsp_t      mem_rsp;
	mem_req_t      mem_req;
	fetch_packet_t fetch_packet;

	// reference model state
	logic [xlen-1:0] exp_pc;
	logic            shadow_valid [32];
	logic [23:0]     shadow_tag [32];
	mem_tag_t        out_tag;
	logic [xlen-1:0] out_line;
	logic [xlen-1:0] history [$];
	logic            last_hit;
	logic            last_load;
	logic            last_valid;
	int              errors;
	int              test_errors;

	clock_gen clock_gen_inst (.clock(clock), .rst_n(rst_n));

	mem_model mem_model_inst (
		.clock   (clock),
		.rst_n   (rst_n),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

	fetch_top #(.cache_lines(default_cache_lines)) fetch_top_inst (
		.clock        (clock),
		.rst_n        (rst_n),
		.stall        (stall),
		.redirect     (redirect),
		.mem_rsp      (mem_rsp),
		.mem_req      (mem_req),
		.fetch_packet (fetch_packet)
	);

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	// pc and inst matter only when a packet is expected or seen
	task automatic check_packet(input string name, input fetch_packet_t exp,
			input fetch_packet_t act);
		if ((exp.valid || act.valid) && exp !== act) begin
			$display("FAIL %s packet expected valid=%0b pc=%08h inst=%08h actual valid=%0b pc=%08h inst=%08h",
				name, exp.valid, exp.pc, exp.inst, act.valid, act.pc, act.inst);
			test_errors++;
		end
	endtask

	// address matters only for a load
	task automatic check_req(input string name, input mem_req_t exp, input mem_req_t act);
		if (exp.command == cmd_load ? exp !== act : exp.command !== act.command) begin
			$display("FAIL %s request expected cmd=%0d addr=%08h actual cmd=%0d addr=%08h",
				name, exp.command, exp.addr, act.command, act.addr);
			test_errors++;
		end
	endtask

	function automatic logic shadow_hit(input logic [xlen-1:0] addr);
		return shadow_valid[addr[7:3]] && shadow_tag[addr[7:3]] == addr[31:8];
	endfunction

	//////////////////////////////////////////////////
	// one cycle entered and left at a falling edge
	//////////////////////////////////////////////////

	task automatic run_cycle(input string name, input logic nstall, input redirect_t nredir);
		fetch_packet_t   exp_pkt;
		mem_req_t        exp_req;
		logic [xlen-1:0] line_addr;
		line_addr       = {exp_pc[31:3], 3'b000};
		last_hit        = shadow_hit(exp_pc);
		exp_pkt.valid   = last_hit && !stall && !redirect.valid;
		exp_pkt.pc      = exp_pc;
		exp_pkt.inst    = mem_model_inst.read_word(exp_pc);
		exp_req.command = (!last_hit && out_tag == '0) ? cmd_load : cmd_none;
		exp_req.addr    = line_addr;
		check_packet(name, exp_pkt, fetch_packet);
		check_req(name, exp_req, mem_req);
		last_load  = (mem_req.command == cmd_load);
		last_valid = fetch_packet.valid;
		if (exp_pkt.valid) begin
			history.push_back(exp_pc);
			if (history.size() > 256) begin
				void'(history.pop_front());
			end
		end
		// outstanding miss and fills as seen on the ports
		if (mem_req.command == cmd_load && mem_rsp.response != '0) begin
			out_tag  = mem_rsp.response;
			out_line = line_addr;
		end else if (out_tag != '0 && mem_rsp.tag == out_tag) begin
			shadow_valid[out_line[7:3]] = 1'b1;
			shadow_tag[out_line[7:3]]   = out_line[31:8];
			out_tag = '0;
		end
		if (redirect.valid) begin
			exp_pc = redirect.target;
		end else if (exp_pkt.valid) begin
			exp_pc = exp_pc + 32'd4;
		end
		@(posedge clock);
		stall    <= nstall;
		redirect <= nredir;
		@(negedge clock);
	endtask

	task automatic finish_test(input string name);
		$display("test %s done, %0d errors", name, test_errors);
		errors += test_errors;
		test_errors = 0;
	endtask

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////

	initial begin
		redirect_t       none;
		redirect_t       jump;
		fetch_packet_t   exp_pkt;
		mem_req_t        exp_req;
		int              loads;
		int              packets;
		logic [xlen-1:0] target;
		stall       = 1'b0;
		redirect    = '0;
		none        = '0;
		exp_pc      = reset_pc;
		out_tag     = '0;
		out_line    = '0;
		errors      = 0;
		test_errors = 0;
		for (int i = 0; i < 32; i++) begin
			shadow_valid[i] = 1'b0;
			shadow_tag[i]   = '0;
		end

		// no request and no packet while reset is held
		exp_pkt = '0;
		exp_req.command = cmd_none;
		exp_req.addr    = {reset_pc[31:3], 3'b000};
		@(negedge clock);
		while (!rst_n) begin
			check_packet("reset", exp_pkt, fetch_packet);
			check_req("reset", exp_req, mem_req);
			@(negedge clock);
		end
		finish_test("reset");

		// random stall levels and far redirects
		for (int i = 0; i < 600; i++) begin
			jump.valid  = ($urandom_range(0, 31) == 0);
			jump.target = {16'h0, 14'($urandom_range(0, 16383)), 2'b00};
			run_cycle("random_run", $urandom_range(0, 3) == 0, jump);
		end
		finish_test("random_run");

		// jumps back to pcs fetched earlier
		for (int i = 0; i < 400; i++) begin
			jump.valid  = ($urandom_range(0, 15) == 0) && history.size() > 0;
			jump.target = jump.valid ? history[$urandom_range(0, history.size() - 1)] : '0;
			run_cycle("loop_back", $urandom_range(0, 4) == 0, jump);
		end
		finish_test("loop_back");

		// held lines deliver with no memory traffic
		loads   = 0;
		packets = 0;
		for (int attempt = 0; attempt < 8; attempt++) begin
			target = exp_pc;
			foreach (history[k]) begin
				if (shadow_hit(history[k])) begin
					target = history[k];
				end
			end
			jump.valid  = 1'b1;
			jump.target = target;
			run_cycle("reuse", 1'b0, jump);
			run_cycle("reuse", 1'b0, none);
			for (int k = 0; k < 16; k++) begin
				run_cycle("reuse", 1'b0, none);
				if (!last_hit) begin
					break;
				end
				loads += last_load;
				packets += last_valid;
			end
		end
		if (packets == 0) begin
			$display("reuse: no packet was delivered from a held line");
			test_errors++;
		end
		if (loads != 0) begin
			$display("reuse: %0d memory loads were issued for held lines", loads);
			test_errors++;
		end
		finish_test("reuse");

		$display("tests done: 4 run, %0d errors", errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// watchdog at 20 cycles per fetch of 100 ns
	initial begin
		#(total_cycles * 20 * 100);
		$display("timeout: the run did not finish in %0d cycles", total_cycles * 20);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
verilog/fetch_pkg.sv
verilog/icache_mem.sv
verilog/icache_ctrl.sv
verilog/fetch_pc.sv
verilog/fetch_top.sv
sim/clock_gen.sv
sim/mem_model.sv
sim/fetch_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= fetch_tb
RTL_TOP   ?= fetch_top
FILELIST  ?= list.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
